// ==== source/soc_fabric_pkg.sv ====
`default_nettype none

package soc_fabric_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;
  typedef logic [3:0]  region_t;   // adr[31:28]
  typedef logic [15:0] count_t;
  typedef logic [2:0]  irq_t;

  // region map, anything else is unmapped
  localparam region_t REGION_ROM = 4'h2;
  localparam region_t REGION_IO  = 4'h4;
  localparam region_t REGION_RAM = 4'h7;

  localparam irq_t IRQ_NONE  = 3'd0;
  localparam irq_t IRQ_FAULT = 3'd1;
  localparam irq_t IRQ_TIMER = 3'd2;

  // io word offsets, adr[3:2]
  localparam logic [1:0] IO_RELOAD  = 2'd0;
  localparam logic [1:0] IO_CONTROL = 2'd1;   // 0 timer en, 1 irq en
  localparam logic [1:0] IO_STATUS  = 2'd2;   // 0 timer, 1 fault; w1c

  typedef enum logic [1:0] {
    ARB_IDLE,
    CPU_OWN,
    FETCH_OWN,
    RELEASE
  } arb_state_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    REQUEST,
    WAIT_ACK
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== source/bus_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_decoder (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  soc_fabric_pkg::addr_t cpu_adr_i,
  input  logic                  cpu_cyc_i,
  input  logic                  cpu_stb_i,
  input  soc_fabric_pkg::data_t rom_dat_i,
  input  logic                  rom_ack_i,
  input  soc_fabric_pkg::data_t io_dat_i,
  input  logic                  io_ack_i,
  input  soc_fabric_pkg::data_t ram_dat_i,
  input  logic                  cpu_ram_ack_i,
  output logic                  rom_stb_o,
  output logic                  io_stb_o,
  output logic                  cpu_ram_req_o,
  output soc_fabric_pkg::data_t cpu_dat_o,
  output logic                  cpu_ack_o,
  output logic                  cpu_err_o,
  output logic                  fault_pulse_o
);

  soc_fabric_pkg::region_t region;
  logic req;
  logic unmapped_req;
  logic ack;
  logic err_q;
  logic err_done;   // err already given this bus cycle

  assign region = cpu_adr_i[31:28];
  assign req    = cpu_cyc_i & cpu_stb_i;

  assign rom_stb_o     = req & (region == soc_fabric_pkg::REGION_ROM);
  assign io_stb_o      = req & (region == soc_fabric_pkg::REGION_IO);
  assign cpu_ram_req_o = req & (region == soc_fabric_pkg::REGION_RAM);
  assign unmapped_req  = req & ~(rom_stb_o | io_stb_o | cpu_ram_req_o);

  // return path follows the region of the held address
  always_comb begin
    cpu_dat_o = '0;
    ack = 1'b0;
    case (region)
      soc_fabric_pkg::REGION_ROM: begin
        cpu_dat_o = rom_dat_i;
        ack = rom_ack_i;
      end
      soc_fabric_pkg::REGION_IO: begin
        cpu_dat_o = io_dat_i;
        ack = io_ack_i;
      end
      soc_fabric_pkg::REGION_RAM: begin
        cpu_dat_o = ram_dat_i;
        ack = cpu_ram_ack_i;
      end
      default: ;
    endcase
  end

  assign cpu_ack_o = ack & req;   // drops with cyc

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
      err_done <= 1'b0;
    end else begin
      err_q <= unmapped_req & ~err_q & ~err_done;
      if (!cpu_cyc_i)
        err_done <= 1'b0;
      else if (err_q)
        err_done <= 1'b1;
    end
  end

  assign cpu_err_o     = err_q;
  assign fault_pulse_o = err_q;   // one per bus cycle

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  logic                  cpu_ram_req_i,
  input  soc_fabric_pkg::addr_t cpu_adr_i,
  input  soc_fabric_pkg::data_t cpu_dat_i,
  input  soc_fabric_pkg::sel_t  cpu_sel_i,
  input  logic                  cpu_we_i,
  input  logic                  fetch_cyc_i,
  input  soc_fabric_pkg::addr_t fetch_adr_i,
  input  logic                  ram_ack_i,
  output logic                  cpu_gnt_o,
  output logic                  fetch_gnt_o,
  output logic                  ram_stb_o,
  output soc_fabric_pkg::addr_t ram_adr_o,
  output soc_fabric_pkg::data_t ram_dat_o,
  output soc_fabric_pkg::sel_t  ram_sel_o,
  output logic                  ram_we_o,
  output logic                  cpu_ram_ack_o,
  output logic                  fetch_ack_o
);

  soc_fabric_pkg::arb_state_t state;
  soc_fabric_pkg::arb_state_t state_nxt;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i)
      state <= soc_fabric_pkg::ARB_IDLE;
    else
      state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      soc_fabric_pkg::ARB_IDLE: begin
        if (fetch_cyc_i)   // fetcher first
          state_nxt = soc_fabric_pkg::FETCH_OWN;
        else if (cpu_ram_req_i)
          state_nxt = soc_fabric_pkg::CPU_OWN;
      end
      soc_fabric_pkg::CPU_OWN,
      soc_fabric_pkg::FETCH_OWN: begin
        if (ram_ack_i)
          state_nxt = soc_fabric_pkg::RELEASE;
      end
      soc_fabric_pkg::RELEASE: state_nxt = soc_fabric_pkg::ARB_IDLE;
      default: state_nxt = soc_fabric_pkg::ARB_IDLE;
    endcase
  end

  assign cpu_gnt_o   = (state == soc_fabric_pkg::CPU_OWN);
  assign fetch_gnt_o = (state == soc_fabric_pkg::FETCH_OWN);

  // owner drives the ram, fetcher only ever reads whole words
  assign ram_stb_o = (cpu_gnt_o & cpu_ram_req_i) | (fetch_gnt_o & fetch_cyc_i);
  assign ram_adr_o = cpu_gnt_o ? cpu_adr_i : fetch_adr_i;
  assign ram_dat_o = cpu_gnt_o ? cpu_dat_i : '0;
  assign ram_sel_o = cpu_gnt_o ? cpu_sel_i : 4'hf;
  assign ram_we_o  = cpu_gnt_o & cpu_we_i;

  assign cpu_ram_ack_o = cpu_gnt_o & ram_ack_i;
  assign fetch_ack_o   = fetch_gnt_o & ram_ack_i;

endmodule

`default_nettype wire

// ==== source/line_fetcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_fetcher #(
  parameter int RAM_AWIDTH  = 8,
  parameter int FETCH_WORDS = 4,
  parameter int FB_BASE     = 16
) (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  logic                  fetch_start_i,
  input  logic                  fetch_gnt_i,
  input  logic                  fetch_ack_i,
  input  soc_fabric_pkg::data_t ram_dat_i,
  output logic                  fetch_cyc_o,
  output soc_fabric_pkg::addr_t fetch_adr_o,
  output soc_fabric_pkg::data_t pixel_o,
  output logic                  pixel_valid_o
);

  localparam int CNT_W = $clog2(FETCH_WORDS + 1);

  soc_fabric_pkg::fetch_state_t state;
  logic [RAM_AWIDTH-1:0] word_q;
  logic [CNT_W-1:0] left_q;   // words still to read
  soc_fabric_pkg::data_t pixel_q;
  logic valid_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state <= soc_fabric_pkg::FETCH_IDLE;
      word_q <= '0;
      left_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        soc_fabric_pkg::FETCH_IDLE: begin
          if (fetch_start_i) begin
            word_q <= RAM_AWIDTH'(FB_BASE);
            left_q <= CNT_W'(FETCH_WORDS);
            state <= soc_fabric_pkg::REQUEST;
          end
        end
        soc_fabric_pkg::REQUEST: begin
          if (fetch_gnt_i)
            state <= soc_fabric_pkg::WAIT_ACK;
        end
        soc_fabric_pkg::WAIT_ACK: begin
          if (fetch_ack_i) begin
            valid_q <= 1'b1;
            word_q <= word_q + 1'b1;
            left_q <= left_q - 1'b1;
            if (left_q == CNT_W'(1))
              state <= soc_fabric_pkg::FETCH_IDLE;
            else
              state <= soc_fabric_pkg::REQUEST;
          end
        end
        default: state <= soc_fabric_pkg::FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge sysclock) begin
    if (state == soc_fabric_pkg::WAIT_ACK && fetch_ack_i)
      pixel_q <= ram_dat_i;
  end

  assign fetch_cyc_o   = (state != soc_fabric_pkg::FETCH_IDLE);
  assign fetch_adr_o   = {soc_fabric_pkg::REGION_RAM, {(26 - RAM_AWIDTH){1'b0}}, word_q, 2'b00};
  assign pixel_o       = pixel_q;
  assign pixel_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== source/io_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_timer (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  logic                  io_stb_i,
  input  soc_fabric_pkg::addr_t cpu_adr_i,
  input  soc_fabric_pkg::data_t cpu_dat_i,
  input  logic                  cpu_we_i,
  input  logic                  fault_pulse_i,
  output soc_fabric_pkg::data_t io_dat_o,
  output logic                  io_ack_o,
  output logic                  fetch_start_o,
  output soc_fabric_pkg::irq_t  irq_o
);

  soc_fabric_pkg::count_t reload_q;
  soc_fabric_pkg::count_t count_q;
  soc_fabric_pkg::data_t dat_q;
  logic [1:0] ctrl_q;
  logic [1:0] pend_q;
  logic [1:0] off;
  logic [1:0] clr;
  logic ack_q;
  logic start_q;
  logic wr;
  logic expire;

  assign off    = cpu_adr_i[3:2];
  assign wr     = io_stb_i & cpu_we_i & ~ack_q;   // once per access
  assign expire = ctrl_q[0] & (count_q == '0);
  assign clr    = (wr && off == soc_fabric_pkg::IO_STATUS) ? cpu_dat_i[1:0] : 2'b00;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      reload_q <= '0;
      count_q <= '0;
      ctrl_q <= 2'b00;
      pend_q <= 2'b00;
      ack_q <= 1'b0;
      start_q <= 1'b0;
    end else begin
      ack_q <= io_stb_i & ~ack_q;
      start_q <= expire;
      if (wr && off == soc_fabric_pkg::IO_RELOAD)
        reload_q <= cpu_dat_i[15:0];
      if (wr && off == soc_fabric_pkg::IO_CONTROL)
        ctrl_q <= cpu_dat_i[1:0];
      if (!ctrl_q[0] || expire)
        count_q <= reload_q;   // parked or reloading
      else
        count_q <= count_q - 1'b1;
      // new events win over a clear in the same cycle
      pend_q <= (pend_q & ~clr) | {fault_pulse_i, expire};
    end
  end

  always_ff @(posedge sysclock) begin
    if (io_stb_i && !ack_q) begin
      case (off)
        soc_fabric_pkg::IO_RELOAD:  dat_q <= {16'h0, reload_q};
        soc_fabric_pkg::IO_CONTROL: dat_q <= {30'h0, ctrl_q};
        soc_fabric_pkg::IO_STATUS:  dat_q <= {30'h0, pend_q};
        default:                    dat_q <= '0;
      endcase
    end
  end

  // fault ahead of timer
  always_comb begin
    irq_o = soc_fabric_pkg::IRQ_NONE;
    if (ctrl_q[1]) begin
      if (pend_q[1])
        irq_o = soc_fabric_pkg::IRQ_FAULT;
      else if (pend_q[0])
        irq_o = soc_fabric_pkg::IRQ_TIMER;
    end
  end

  assign io_dat_o      = dat_q;
  assign io_ack_o      = ack_q;
  assign fetch_start_o = start_q;

endmodule

`default_nettype wire

// ==== source/onchip_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module onchip_rom (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  logic                  rom_stb_i,
  input  logic                  cpu_cyc_i,
  input  logic                  cpu_we_i,
  input  soc_fabric_pkg::addr_t cpu_adr_i,
  output soc_fabric_pkg::data_t rom_dat_o,
  output logic                  rom_ack_o
);

  logic [15:0] idx;
  logic [1:0] ack_sr;
  soc_fabric_pkg::data_t dat_q;

  assign idx = cpu_adr_i[17:2];

  // two stage ack, flushed between bus cycles
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i)
      ack_sr <= 2'b00;
    else if (!cpu_cyc_i)
      ack_sr <= 2'b00;
    else
      ack_sr <= {ack_sr[0], rom_stb_i};
  end

  always_ff @(posedge sysclock) begin
    if (rom_stb_i && !cpu_we_i)
      dat_q <= {idx, ~idx};   // word index over its inverse
  end

  assign rom_dat_o = dat_q;
  assign rom_ack_o = ack_sr[1];

endmodule

`default_nettype wire

// ==== source/shared_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module shared_ram #(
  parameter int RAM_AWIDTH = 8
) (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  logic                  ram_stb_i,
  input  soc_fabric_pkg::addr_t ram_adr_i,
  input  soc_fabric_pkg::data_t ram_dat_i,
  input  soc_fabric_pkg::sel_t  ram_sel_i,
  input  logic                  ram_we_i,
  output soc_fabric_pkg::data_t ram_dat_o,
  output logic                  ram_ack_o
);

  localparam int DEPTH = 2 ** RAM_AWIDTH;

  soc_fabric_pkg::data_t mem [DEPTH];
  soc_fabric_pkg::data_t rd_q;
  logic [RAM_AWIDTH-1:0] word;
  logic ack_q;

  assign word = ram_adr_i[RAM_AWIDTH+1:2];

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= ram_stb_i & ~ack_q;   // single pulse per strobe
  end

  always_ff @(posedge sysclock) begin
    if (ram_stb_i && !ack_q) begin
      if (ram_we_i) begin
        for (int i = 0; i < 4; i++) begin
          if (ram_sel_i[i])
            mem[word][8*i +: 8] <= ram_dat_i[8*i +: 8];
        end
      end
      rd_q <= mem[word];
    end
  end

  assign ram_dat_o = rd_q;
  assign ram_ack_o = ack_q;

endmodule

`default_nettype wire

// ==== source/soc_fabric.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_fabric #(
  parameter int RAM_AWIDTH  = 8,
  parameter int FETCH_WORDS = 4,
  parameter int FB_BASE     = 16
) (
  input  logic                  sysclock,
  input  logic                  rst_i,
  input  soc_fabric_pkg::addr_t cpu_adr_i,
  input  soc_fabric_pkg::data_t cpu_dat_i,
  input  soc_fabric_pkg::sel_t  cpu_sel_i,
  input  logic                  cpu_we_i,
  input  logic                  cpu_cyc_i,
  input  logic                  cpu_stb_i,
  output soc_fabric_pkg::data_t cpu_dat_o,
  output logic                  cpu_ack_o,
  output logic                  cpu_err_o,
  output soc_fabric_pkg::irq_t  irq_o,
  output soc_fabric_pkg::data_t pixel_o,
  output logic                  pixel_valid_o
);

  soc_fabric_pkg::data_t rom_dat, io_dat, ram_dat, ram_wdat;
  soc_fabric_pkg::addr_t fetch_adr, ram_adr;
  soc_fabric_pkg::sel_t ram_sel;
  logic rom_stb, rom_ack, io_stb, io_ack;
  logic cpu_ram_req, cpu_ram_ack;
  logic fetch_cyc, fetch_gnt, fetch_ack, fetch_start;
  logic ram_stb, ram_we, ram_ack, fault_pulse;

  bus_decoder dec0(.sysclock(sysclock), .rst_i(rst_i), .cpu_adr_i(cpu_adr_i),
    .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i), .rom_dat_i(rom_dat), .rom_ack_i(rom_ack),
    .io_dat_i(io_dat), .io_ack_i(io_ack), .ram_dat_i(ram_dat), .cpu_ram_ack_i(cpu_ram_ack),
    .rom_stb_o(rom_stb), .io_stb_o(io_stb), .cpu_ram_req_o(cpu_ram_req),
    .cpu_dat_o(cpu_dat_o), .cpu_ack_o(cpu_ack_o), .cpu_err_o(cpu_err_o),
    .fault_pulse_o(fault_pulse));

  // ram shared between cpu and line fetcher
  mem_arbiter arb0(.sysclock(sysclock), .rst_i(rst_i), .cpu_ram_req_i(cpu_ram_req),
    .cpu_adr_i(cpu_adr_i), .cpu_dat_i(cpu_dat_i), .cpu_sel_i(cpu_sel_i), .cpu_we_i(cpu_we_i),
    .fetch_cyc_i(fetch_cyc), .fetch_adr_i(fetch_adr), .ram_ack_i(ram_ack),
    .cpu_gnt_o(), .fetch_gnt_o(fetch_gnt), .ram_stb_o(ram_stb), .ram_adr_o(ram_adr),
    .ram_dat_o(ram_wdat), .ram_sel_o(ram_sel), .ram_we_o(ram_we),
    .cpu_ram_ack_o(cpu_ram_ack), .fetch_ack_o(fetch_ack));

  line_fetcher #(.RAM_AWIDTH(RAM_AWIDTH), .FETCH_WORDS(FETCH_WORDS), .FB_BASE(FB_BASE))
    fetch0(.sysclock(sysclock), .rst_i(rst_i), .fetch_start_i(fetch_start),
    .fetch_gnt_i(fetch_gnt), .fetch_ack_i(fetch_ack), .ram_dat_i(ram_dat),
    .fetch_cyc_o(fetch_cyc), .fetch_adr_o(fetch_adr), .pixel_o(pixel_o),
    .pixel_valid_o(pixel_valid_o));

  io_timer io0(.sysclock(sysclock), .rst_i(rst_i), .io_stb_i(io_stb), .cpu_adr_i(cpu_adr_i),
    .cpu_dat_i(cpu_dat_i), .cpu_we_i(cpu_we_i), .fault_pulse_i(fault_pulse),
    .io_dat_o(io_dat), .io_ack_o(io_ack), .fetch_start_o(fetch_start), .irq_o(irq_o));

  onchip_rom rom0(.sysclock(sysclock), .rst_i(rst_i), .rom_stb_i(rom_stb),
    .cpu_cyc_i(cpu_cyc_i), .cpu_we_i(cpu_we_i), .cpu_adr_i(cpu_adr_i),
    .rom_dat_o(rom_dat), .rom_ack_o(rom_ack));

  shared_ram #(.RAM_AWIDTH(RAM_AWIDTH)) ram0(.sysclock(sysclock), .rst_i(rst_i),
    .ram_stb_i(ram_stb), .ram_adr_i(ram_adr), .ram_dat_i(ram_wdat), .ram_sel_i(ram_sel),
    .ram_we_i(ram_we), .ram_dat_o(ram_dat), .ram_ack_o(ram_ack));

endmodule

`default_nettype wire

// ==== bench/soc_fabric_tb_table.svh ====
// columns: dir, address, write data, select, expected read data, response, expected irq
task automatic fill_table();
  // rom, word index over its inverse
  add_row(RD, 32'h2000_0000, 32'h0, 4'hf, 32'h0000_ffff, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2000_0010, 32'h0, 4'hf, 32'h0004_fffb, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2003_fffc, 32'h0, 4'hf, 32'hffff_0000, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2000_1234, 32'h0, 4'hf, 32'h048d_fb72, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h2000_0010, 32'hdead_beef, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2000_0010, 32'h0, 4'hf, 32'h0004_fffb, RESP_ACK, IRQ_SKIP);   // write ignored
  // io registers out of reset
  add_row(RD, IO_RELOAD_ADR, 32'h0, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_NONE);
  add_row(RD, IO_STATUS_ADR, 32'h0, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_NONE);
  // ram byte lanes
  add_row(WR, 32'h7000_0008, 32'h1122_3344, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h7000_0008, 32'haabb_ccdd, 4'h5, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h7000_0008, 32'h0, 4'hf, 32'h11bb_33dd, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h7000_0008, 32'h9900_0000, 4'h8, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h7000_0008, 32'h0, 4'hf, 32'h99bb_33dd, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h7000_000c, 32'h5566_7788, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h7000_000c, 32'h0000_ee00, 4'h2, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h7000_000c, 32'h0, 4'hf, 32'h5566_ee88, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h7000_000c, 32'hffff_ffff, 4'h0, 32'h0, RESP_ACK, IRQ_SKIP);   // no lanes
  add_row(RD, 32'h7000_000c, 32'h0, 4'hf, 32'h5566_ee88, RESP_ACK, IRQ_SKIP);
  // line buffer words
  for (int k = 0; k < FETCH_WORDS; k++)
    add_row(WR, fb_adr(k), FB_DATA[k], 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, fb_adr(2), 32'h0, 4'hf, FB_DATA[2], RESP_ACK, IRQ_SKIP);
  // unmapped, fault pending with irq enable clear
  add_row(RD, 32'h0000_0000, 32'h0, 4'hf, 32'h0, RESP_ERR, IRQ_SKIP);
  add_row(RD, IO_STATUS_ADR, 32'h0, 4'hf, 32'h2, RESP_ACK, soc_fabric_pkg::IRQ_NONE);
  add_row(WR, IO_STATUS_ADR, 32'h2, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, IO_STATUS_ADR, 32'h0, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'hf000_0004, 32'h1234_5678, 4'hf, 32'h0, RESP_ERR, IRQ_SKIP);
  add_row(RD, 32'h5000_0000, 32'h0, 4'hf, 32'h0, RESP_ERR, IRQ_SKIP);
  // timer, expiry 11 cycles after the enable
  add_row(WR, IO_RELOAD_ADR, 32'd10, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, IO_RELOAD_ADR, 32'h0, 4'hf, 32'd10, RESP_ACK, IRQ_SKIP);
  add_row(WR, IO_CONTROL_ADR, 32'h3, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  // rom reads span the time to the first expiry
  add_row(RD, 32'h2000_0004, 32'h0, 4'hf, 32'h0001_fffe, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2000_0008, 32'h0, 4'hf, 32'h0002_fffd, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2000_000c, 32'h0, 4'hf, 32'h0003_fffc, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h2000_0100, 32'h0, 4'hf, 32'h0040_ffbf, RESP_ACK, IRQ_SKIP);
  add_row(RD, IO_STATUS_ADR, 32'h0, 4'hf, 32'h3, RESP_ACK, soc_fabric_pkg::IRQ_FAULT);
  add_row(WR, IO_STATUS_ADR, 32'h2, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_TIMER);
  add_row(WR, IO_CONTROL_ADR, 32'h2, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_TIMER);
  add_row(RD, IO_CONTROL_ADR, 32'h0, 4'hf, 32'h2, RESP_ACK, soc_fabric_pkg::IRQ_TIMER);
  // cpu ram traffic while the line fetch runs
  add_row(RD, 32'h7000_0008, 32'h0, 4'hf, 32'h99bb_33dd, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h7000_000c, 32'h0, 4'hf, 32'h5566_ee88, RESP_ACK, IRQ_SKIP);
  add_row(WR, 32'h7000_0010, 32'h0f0f_0f0f, 4'hf, 32'h0, RESP_ACK, IRQ_SKIP);
  add_row(RD, 32'h7000_0010, 32'h0, 4'hf, 32'h0f0f_0f0f, RESP_ACK, IRQ_SKIP);
  add_row(RD, fb_adr(0), 32'h0, 4'hf, FB_DATA[0], RESP_ACK, IRQ_SKIP);
  // nothing pending, then irq enable off
  add_row(WR, IO_STATUS_ADR, 32'h1, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_NONE);
  add_row(RD, IO_STATUS_ADR, 32'h0, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_NONE);
  add_row(WR, IO_CONTROL_ADR, 32'h0, 4'hf, 32'h0, RESP_ACK, soc_fabric_pkg::IRQ_NONE);
endtask

// ==== bench/soc_fabric_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_fabric_tb;

  localparam int RAM_AWIDTH  = 8;
  localparam int FETCH_WORDS = 4;
  localparam int FB_BASE     = 16;

  localparam logic RD       = 1'b0;
  localparam logic WR       = 1'b1;
  localparam logic RESP_ACK = 1'b0;
  localparam logic RESP_ERR = 1'b1;
  localparam soc_fabric_pkg::irq_t IRQ_SKIP = 3'd7;   // row has no irq check

  localparam soc_fabric_pkg::addr_t IO_RELOAD_ADR  = 32'h4000_0000;
  localparam soc_fabric_pkg::addr_t IO_CONTROL_ADR = 32'h4000_0004;
  localparam soc_fabric_pkg::addr_t IO_STATUS_ADR  = 32'h4000_0008;

  // line contents written by the table and expected on pixel_o
  localparam soc_fabric_pkg::data_t FB_DATA [FETCH_WORDS] = '{
    32'h0bad_f00d, 32'h1234_5678, 32'hdead_beef, 32'h600d_cafe
  };

  logic                  sysclock;
  logic                  rst_i;
  soc_fabric_pkg::addr_t cpu_adr_i;
  soc_fabric_pkg::data_t cpu_dat_i;
  soc_fabric_pkg::sel_t  cpu_sel_i;
  logic                  cpu_we_i;
  logic                  cpu_cyc_i;
  logic                  cpu_stb_i;
  soc_fabric_pkg::data_t cpu_dat_o;
  logic                  cpu_ack_o;
  logic                  cpu_err_o;
  soc_fabric_pkg::irq_t  irq_o;
  soc_fabric_pkg::data_t pixel_o;
  logic                  pixel_valid_o;

  logic                  row_we [$];
  soc_fabric_pkg::addr_t row_adr [$];
  soc_fabric_pkg::data_t row_dat [$];
  soc_fabric_pkg::sel_t  row_sel [$];
  soc_fabric_pkg::data_t row_exp [$];
  logic                  row_resp [$];
  soc_fabric_pkg::irq_t  row_irq [$];

  int cycle_count = 0;
  int cycle_limit = 400;
  int pix_count = 0;

  soc_fabric #(.RAM_AWIDTH(RAM_AWIDTH), .FETCH_WORDS(FETCH_WORDS), .FB_BASE(FB_BASE)) dut0 (
    .sysclock(sysclock), .rst_i(rst_i), .cpu_adr_i(cpu_adr_i), .cpu_dat_i(cpu_dat_i),
    .cpu_sel_i(cpu_sel_i), .cpu_we_i(cpu_we_i), .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i),
    .cpu_dat_o(cpu_dat_o), .cpu_ack_o(cpu_ack_o), .cpu_err_o(cpu_err_o), .irq_o(irq_o),
    .pixel_o(pixel_o), .pixel_valid_o(pixel_valid_o));

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic add_row(input logic we, input soc_fabric_pkg::addr_t adr,
                         input soc_fabric_pkg::data_t dat, input soc_fabric_pkg::sel_t sel,
                         input soc_fabric_pkg::data_t exp, input logic resp,
                         input soc_fabric_pkg::irq_t irq);
    row_we.push_back(we);
    row_adr.push_back(adr);
    row_dat.push_back(dat);
    row_sel.push_back(sel);
    row_exp.push_back(exp);
    row_resp.push_back(resp);
    row_irq.push_back(irq);
  endtask

  function automatic soc_fabric_pkg::addr_t fb_adr(input int k);
    return {soc_fabric_pkg::REGION_RAM, 28'((FB_BASE + k) * 4)};
  endfunction

  // one classic cycle held until ack or err
  task automatic bus_access(input logic we, input soc_fabric_pkg::addr_t adr,
                            input soc_fabric_pkg::data_t dat, input soc_fabric_pkg::sel_t sel,
                            output soc_fabric_pkg::data_t rdata, output logic ack,
                            output logic err);
    @(posedge sysclock);
    #1;
    cpu_adr_i = adr;
    cpu_dat_i = dat;
    cpu_sel_i = sel;
    cpu_we_i = we;
    cpu_cyc_i = 1'b1;
    cpu_stb_i = 1'b1;
    do begin
      @(posedge sysclock);
      #1;
    end while (!cpu_ack_o && !cpu_err_o);
    rdata = cpu_dat_o;
    ack = cpu_ack_o;
    err = cpu_err_o;
    cpu_cyc_i = 1'b0;
    cpu_stb_i = 1'b0;
    cpu_we_i = 1'b0;
  endtask

  `include "soc_fabric_tb_table.svh"

  initial begin
    sysclock = 1'b0;
    forever #2 sysclock = ~sysclock;
  end

  always @(posedge sysclock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // pixel stream checked mid cycle
  always @(negedge sysclock) begin
    if (pixel_valid_o === 1'b1) begin
      if (pix_count >= FETCH_WORDS) begin
        $display("extra pixel word %h at %0t after the line was complete", pixel_o, $time);
        $display("FAIL: see errors above");
        $fatal(1);
      end else begin
        check_value($sformatf("pixel_o word %0d", pix_count), pixel_o, FB_DATA[pix_count]);
        pix_count = pix_count + 1;
      end
    end
  end

  initial begin
    soc_fabric_pkg::data_t rdata;
    logic ack;
    logic err;
    rst_i = 1'b1;
    cpu_adr_i = '0;
    cpu_dat_i = '0;
    cpu_sel_i = '0;
    cpu_we_i = 1'b0;
    cpu_cyc_i = 1'b0;
    cpu_stb_i = 1'b0;
    fill_table();
    cycle_limit = 40 * row_adr.size() + 400;
    repeat (10) @(posedge sysclock);
    #1 rst_i = 1'b0;
    check_value("cpu_ack_o after reset", 32'(cpu_ack_o), 32'h0);
    check_value("cpu_err_o after reset", 32'(cpu_err_o), 32'h0);
    check_value("irq_o after reset", 32'(irq_o), 32'h0);
    check_value("pixel_valid_o after reset", 32'(pixel_valid_o), 32'h0);
    for (int i = 0; i < row_adr.size(); i++) begin
      bus_access(row_we[i], row_adr[i], row_dat[i], row_sel[i], rdata, ack, err);
      check_value($sformatf("cpu_ack_o row %0d", i), 32'(ack), 32'(row_resp[i] == RESP_ACK));
      check_value($sformatf("cpu_err_o row %0d", i), 32'(err), 32'(row_resp[i] == RESP_ERR));
      if (row_we[i] == RD && row_resp[i] == RESP_ACK)
        check_value($sformatf("cpu_dat_o row %0d", i), rdata, row_exp[i]);
      if (row_irq[i] != IRQ_SKIP)
        check_value($sformatf("irq_o row %0d", i), 32'(irq_o), 32'(row_irq[i]));
    end
    while (pix_count < FETCH_WORDS)
      @(posedge sysclock);
    repeat (50) @(posedge sysclock);   // timer is off so no second line
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_fabric.f ====
+incdir+bench
source/soc_fabric_pkg.sv
source/bus_decoder.sv
source/mem_arbiter.sv
source/line_fetcher.sv
source/io_timer.sv
source/onchip_rom.sv
source/shared_ram.sv
source/soc_fabric.sv
bench/soc_fabric_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = soc_fabric_tb
FILELIST = soc_fabric.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "test failed, no result in log"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
